// File: Makefile
VERILATOR = verilator
VFLAGS    = --binary --timing --assert -j 0
TOP       = uart_tb
FILELIST  = all.f
OBJ_DIR   = obj_dir

.PHONY: help test clean

help:
	@echo "make test   build with Verilator and run the testbench"
	@echo "make clean  remove the build directory"
	@echo "make help   show this list"

test:
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) -f $(FILELIST) --Mdir $(OBJ_DIR)
	@out="$$(./$(OBJ_DIR)/V$(TOP))"; \
	echo "$$out"; \
	echo "$$out" | grep -qx "Result: PASSED"

clean:
	rm -rf $(OBJ_DIR)

// File: all.f
+incdir+logic
logic/uart_pkg.sv
logic/uart_fifo.sv
logic/uart_apb_regs.sv
logic/uart_serial_tx.sv
logic/uart_serial_rx.sv
logic/uart_top.sv
verif/uart_tb_clock.sv
verif/uart_tb.sv

// File: logic/uart_apb_regs.sv
/* APB slave with PREADY tied high; a transfer is one setup and one access cycle
   read data is captured in the setup cycle, a DIV below 4 is stored as 4 */
`timescale 1ns/100ps
`default_nettype none
`include "uart_settings.svh"

module uart_apb_regs (
   input  logic                    clk_i,
   input  logic                    arst_i,
   input  logic                    psel_i,
   input  logic                    penable_i,
   input  logic                    pwrite_i,
   input  logic [`UART_ADDR_W-1:0] paddr_i,
   input  logic [31:0]             pwdata_i,
   output logic [31:0]             prdata_o,
   output logic                    pready_o,
   output logic                    pslverr_o,
   output logic [`UART_DIV_W-1:0]  bit_duration_o,
   output logic                    tx_en_o,
   output logic                    rx_en_o,
   output logic                    soft_rst_o,
   output logic                    tx_push_o,
   output uart_pkg::byte_t         tx_data_o,
   input  logic                    tx_full_i,
   output logic                    rx_pop_o,
   input  uart_pkg::rx_entry_t     rx_head_i,
   input  logic                    rx_empty_i,
   input  logic                    tx_idle_i,
   input  logic                    overrun_i
);

   localparam logic [`UART_DIV_W-1:0] DIV_MIN = `UART_DIV_W'(4);

   logic                   setup;
   logic                   access;
   logic                   sel_div;
   logic                   sel_ctrl;
   logic                   sel_status;
   logic                   sel_tx;
   logic                   sel_rx;
   logic                   mapped;
   logic [`UART_DIV_W-1:0] div_q;
   logic                   tx_en_q;
   logic                   rx_en_q;
   logic                   soft_rst_q;
   logic                   overrun_q;
   logic                   rx_avail_q;   // rx fifo held a byte at setup
   logic [31:0]            rd_data;
   logic [31:0]            prdata_q;

   assign setup      = psel_i & ~penable_i;
   assign access     = psel_i & penable_i;
   assign sel_div    = (paddr_i == `UART_REG_DIV);
   assign sel_ctrl   = (paddr_i == `UART_REG_CTRL);
   assign sel_status = (paddr_i == `UART_REG_STATUS);
   assign sel_tx     = (paddr_i == `UART_REG_TXDATA);
   assign sel_rx     = (paddr_i == `UART_REG_RXDATA);
   assign mapped     = sel_div | sel_ctrl | sel_status | sel_tx | sel_rx;

   ////////////////////////////////////////////////////////////
   // register writes, taken in the access cycle
   always_ff @(posedge clk_i or negedge arst_i) begin
      if (!arst_i) begin
         div_q      <= DIV_MIN;
         tx_en_q    <= 1'b0;
         rx_en_q    <= 1'b0;
         soft_rst_q <= 1'b0;
         overrun_q  <= 1'b0;
      end else begin
         soft_rst_q <= 1'b0;                     // pulse for one cycle
         if (overrun_i) begin
            overrun_q <= 1'b1;                   // set beats clear
         end else if (soft_rst_q) begin
            overrun_q <= 1'b0;
         end else if (access && pwrite_i && sel_status && pwdata_i[3]) begin
            overrun_q <= 1'b0;                   // write 1 to clear
         end
         if (access && pwrite_i && sel_div) begin
            div_q <= (pwdata_i[`UART_DIV_W-1:0] < DIV_MIN) ?
                     DIV_MIN : pwdata_i[`UART_DIV_W-1:0];
         end
         if (access && pwrite_i && sel_ctrl) begin
            tx_en_q    <= pwdata_i[uart_pkg::CTRL_TX_EN];
            rx_en_q    <= pwdata_i[uart_pkg::CTRL_RX_EN];
            soft_rst_q <= pwdata_i[uart_pkg::CTRL_SOFT_RST];
         end
      end
   end

   ////////////////////////////////////////////////////////////
   // read mux, registered in the setup cycle
   always_comb begin
      rd_data = '0;
      case (paddr_i)
         `UART_REG_DIV: rd_data[`UART_DIV_W-1:0] = div_q;
         `UART_REG_CTRL: begin
            rd_data[uart_pkg::CTRL_TX_EN] = tx_en_q;
            rd_data[uart_pkg::CTRL_RX_EN] = rx_en_q;
         end
         `UART_REG_STATUS: rd_data[3:0] = {overrun_q, ~rx_empty_i, tx_idle_i, tx_full_i};
         `UART_REG_RXDATA: begin
            if (!rx_empty_i)
               rd_data[8:0] = rx_head_i;         // zero when empty
         end
         default: rd_data = '0;
      endcase
   end

   always_ff @(posedge clk_i or negedge arst_i) begin
      if (!arst_i) begin
         prdata_q   <= '0;
         rx_avail_q <= 1'b0;
      end else if (setup && !pwrite_i) begin
         prdata_q   <= rd_data;
         rx_avail_q <= ~rx_empty_i;
      end
   end

   assign prdata_o       = prdata_q;
   assign pready_o       = 1'b1;
   assign bit_duration_o = div_q;
   assign tx_en_o        = tx_en_q;
   assign rx_en_o        = rx_en_q;
   assign soft_rst_o     = soft_rst_q;
   assign tx_data_o      = pwdata_i[7:0];
   assign tx_push_o      = access & pwrite_i & sel_tx & ~tx_full_i;
   assign rx_pop_o       = access & ~pwrite_i & sel_rx & rx_avail_q;
   assign pslverr_o      = access & (~mapped | (pwrite_i & sel_tx & tx_full_i) |
                                     (~pwrite_i & sel_rx & ~rx_avail_q));

   // read data comes from the setup cycle just before
   a_access_after_setup: assert property (@(posedge clk_i) disable iff (!arst_i)
      access |-> $past(setup));

   // an rx pop always finds a byte in the fifo
   a_pop_not_empty: assert property (@(posedge clk_i) disable iff (!arst_i)
      rx_pop_o |-> !rx_empty_i);

endmodule

`default_nettype wire

// File: logic/uart_fifo.sv
/* single-clock FIFO, payload type given by parameter
   a push is refused when full, a pop when empty; clear_i empties it */
`timescale 1ns/100ps
`default_nettype none

module uart_fifo #(
   parameter type         payload_t = logic [7:0],
   parameter int unsigned DEPTH     = 4
) (
   input  logic     clk_i,
   input  logic     arst_i,
   input  logic     clear_i,
   input  logic     push_i,
   input  payload_t data_i,
   input  logic     pop_i,
   output payload_t head_o,
   output logic     full_o,
   output logic     empty_o
);

   localparam int unsigned PTR_W = (DEPTH > 1) ? $clog2(DEPTH) : 1;
   localparam int unsigned CNT_W = $clog2(DEPTH + 1);

   payload_t         mem [DEPTH];
   logic [PTR_W-1:0] wr_ptr;
   logic [PTR_W-1:0] rd_ptr;
   logic [CNT_W-1:0] count;
   logic             push_ok;
   logic             pop_ok;

   function automatic logic [PTR_W-1:0] next_ptr(input logic [PTR_W-1:0] ptr);
      return (ptr == PTR_W'(DEPTH - 1)) ? '0 : ptr + 1'b1;   // wrap
   endfunction

   assign push_ok = push_i & ~full_o;
   assign pop_ok  = pop_i & ~empty_o;
   assign full_o  = (count == CNT_W'(DEPTH));
   assign empty_o = (count == '0);
   assign head_o  = mem[rd_ptr];

   always_ff @(posedge clk_i or negedge arst_i) begin
      if (!arst_i) begin
         wr_ptr <= '0;
         rd_ptr <= '0;
         count  <= '0;
      end else if (clear_i) begin
         wr_ptr <= '0;
         rd_ptr <= '0;
         count  <= '0;
      end else begin
         if (push_ok)
            wr_ptr <= next_ptr(wr_ptr);
         if (pop_ok)
            rd_ptr <= next_ptr(rd_ptr);
         count <= count + CNT_W'(push_ok) - CNT_W'(pop_ok);
      end
   end

   always_ff @(posedge clk_i) begin
      if (push_ok)
         mem[wr_ptr] <= data_i;
   end

   // a refused push leaves a full fifo untouched
   a_no_overflow: assert property (@(posedge clk_i) disable iff (!arst_i)
      (push_i && full_o && !pop_ok && !clear_i) |=> (full_o && $stable(wr_ptr)));

   // a refused pop leaves an empty fifo untouched
   a_no_underflow: assert property (@(posedge clk_i) disable iff (!arst_i)
      (pop_i && empty_o && !push_ok && !clear_i) |=> (empty_o && $stable(rd_ptr)));

endmodule

`default_nettype wire

// File: logic/uart_pkg.sv
/* payload types of the two FIFOs and the CTRL bit positions */
`default_nettype none

package uart_pkg;

   // one data byte, the transmit fifo payload
   typedef logic [7:0] byte_t;

   // receive fifo payload, frame_err lands in bit 8
   typedef struct packed {
      logic  frame_err;
      byte_t data;
   } rx_entry_t;

   ////////////////////////////////////////////////////////////
   // CTRL register bits
   localparam int unsigned CTRL_TX_EN    = 0;
   localparam int unsigned CTRL_RX_EN    = 1;
   localparam int unsigned CTRL_SOFT_RST = 2;   // self-clearing

endpackage

`default_nettype wire

// File: logic/uart_serial_rx.sv
/* 8N1 receiver; after reset, a disable or a bad frame it first needs a full bit of
   idle line. a byte is pushed half a bit after the stop-bit center, or dropped
   with overrun_o when the rx FIFO is full */
`timescale 1ns/100ps
`default_nettype none
`include "uart_settings.svh"

module uart_serial_rx (
   input  logic                   clk_i,
   input  logic                   arst_i,
   input  logic                   soft_rst_i,
   input  logic                   rx_en_i,
   input  logic [`UART_DIV_W-1:0] bit_duration_i,
   input  logic                   rxd_i,
   input  logic                   full_i,
   output logic                   push_o,
   output uart_pkg::rx_entry_t    entry_o,
   output logic                   overrun_o,
   output logic                   rts_o
);

   typedef enum logic [2:0] {
      S_RESYNC, S_LINE_HIGH, S_WAIT_START, S_START, S_DATA, S_STOP
   } state_t;

   state_t                 state;
   logic [1:0]             rxd_sync;
   logic                   rxd;
   logic                   rts_q;
   logic [`UART_DIV_W-1:0] cyc_cnt;
   logic [`UART_DIV_W-1:0] half_bit;
   logic [3:0]             bit_cnt;
   logic                   sample;     // bit center in the data phase
   logic                   done;
   logic                   frame_err_q;
   uart_pkg::byte_t        shift_q;

   assign rxd      = rxd_sync[1];
   assign half_bit = bit_duration_i >> 1;
   assign sample   = (state == S_DATA) && (cyc_cnt == bit_duration_i);
   assign done     = (state == S_STOP) && (cyc_cnt == half_bit);

   always_ff @(posedge clk_i or negedge arst_i) begin
      if (!arst_i) begin
         rxd_sync <= 2'b11;
         rts_q    <= 1'b0;
      end else begin
         rxd_sync <= {rxd_sync[0], rxd_i};
         rts_q    <= rx_en_i & ~full_i & ~soft_rst_i;   // room for another byte
      end
   end

   ////////////////////////////////////////////////////////////
   // frame detector
   always_ff @(posedge clk_i or negedge arst_i) begin
      if (!arst_i) begin
         state       <= S_RESYNC;
         cyc_cnt     <= `UART_DIV_W'(1);
         bit_cnt     <= '0;
         frame_err_q <= 1'b0;
      end else if (soft_rst_i || !rx_en_i) begin
         state   <= S_RESYNC;
         cyc_cnt <= `UART_DIV_W'(1);
         bit_cnt <= '0;
      end else begin
         cyc_cnt <= cyc_cnt + 1'b1;
         case (state)
            S_RESYNC: begin
               cyc_cnt <= `UART_DIV_W'(1);
               if (rxd)
                  state <= S_LINE_HIGH;
            end
            S_LINE_HIGH: begin
               if (!rxd)
                  state <= S_RESYNC;              // dropped early, start over
               else if (cyc_cnt == bit_duration_i)
                  state <= S_WAIT_START;
            end
            S_WAIT_START: begin
               cyc_cnt <= `UART_DIV_W'(1);
               if (!rxd)
                  state <= S_START;
            end
            S_START: begin
               if (cyc_cnt == half_bit) begin
                  cyc_cnt <= `UART_DIV_W'(1);
                  bit_cnt <= '0;
                  state   <= rxd ? S_RESYNC : S_DATA;   // glitch, not a start bit
               end
            end
            S_DATA: begin
               if (sample) begin
                  cyc_cnt <= `UART_DIV_W'(1);
                  bit_cnt <= bit_cnt + 4'd1;
                  if (bit_cnt == 4'd8) begin
                     frame_err_q <= ~rxd;          // stop bit must be high
                     state       <= S_STOP;
                  end
               end
            end
            S_STOP: begin
               if (done)
                  state <= frame_err_q ? S_RESYNC : S_WAIT_START;
            end
            default: state <= S_RESYNC;
         endcase
      end
   end

   always_ff @(posedge clk_i) begin
      if (sample && bit_cnt != 4'd8)
         shift_q <= {rxd, shift_q[7:1]};          // lsb arrives first
   end

   assign entry_o   = {frame_err_q, shift_q};
   assign push_o    = done & ~full_i;
   assign overrun_o = done & full_i;
   assign rts_o     = rts_q;

endmodule

`default_nettype wire

// File: logic/uart_serial_tx.sv
/* 8N1 transmitter fed from the tx FIFO; a frame starts only while tx is enabled
   and the synchronized cts is high, and a started frame always runs to its stop bit */
`timescale 1ns/100ps
`default_nettype none
`include "uart_settings.svh"

module uart_serial_tx (
   input  logic                   clk_i,
   input  logic                   arst_i,
   input  logic                   soft_rst_i,
   input  logic                   tx_en_i,
   input  logic [`UART_DIV_W-1:0] bit_duration_i,
   input  uart_pkg::byte_t        data_i,
   input  logic                   empty_i,
   input  logic                   cts_i,
   output logic                   pop_o,
   output logic                   txd_o,
   output logic                   idle_o
);

   typedef enum logic [1:0] {S_IDLE, S_LOAD, S_SHIFT} state_t;

   state_t                 state;
   logic [1:0]             cts_sync;
   logic [9:0]             pattern;    // {stop, data, start}, lsb on the line
   logic [3:0]             bit_cnt;
   logic [`UART_DIV_W-1:0] cyc_cnt;

   always_ff @(posedge clk_i or negedge arst_i) begin
      if (!arst_i)
         cts_sync <= 2'b00;
      else
         cts_sync <= {cts_sync[0], cts_i};   // two-flop sync
   end

   ////////////////////////////////////////////////////////////
   // frame sequencer
   always_ff @(posedge clk_i or negedge arst_i) begin
      if (!arst_i) begin
         state   <= S_IDLE;
         pattern <= '1;
         bit_cnt <= '0;
         cyc_cnt <= `UART_DIV_W'(1);
      end else if (soft_rst_i) begin
         state   <= S_IDLE;
         pattern <= '1;
         bit_cnt <= '0;
         cyc_cnt <= `UART_DIV_W'(1);
      end else begin
         case (state)
            S_IDLE: begin
               if (tx_en_i && cts_sync[1] && !empty_i)
                  state <= S_LOAD;
            end
            S_LOAD: begin
               pattern <= {1'b1, data_i, 1'b0};   // fifo head, popped now
               bit_cnt <= '0;
               cyc_cnt <= `UART_DIV_W'(1);
               state   <= S_SHIFT;
            end
            S_SHIFT: begin
               if (cyc_cnt == bit_duration_i) begin
                  cyc_cnt <= `UART_DIV_W'(1);
                  if (bit_cnt == 4'd9) begin
                     state <= S_IDLE;              // stop bit done, line stays high
                  end else begin
                     pattern <= {1'b1, pattern[9:1]};
                     bit_cnt <= bit_cnt + 4'd1;
                  end
               end else begin
                  cyc_cnt <= cyc_cnt + 1'b1;
               end
            end
            default: state <= S_IDLE;
         endcase
      end
   end

   assign pop_o  = (state == S_LOAD);
   assign txd_o  = pattern[0];
   assign idle_o = (state == S_IDLE) & empty_i;   // nothing on the line or queued

   // line rests at mark between frames
   a_idle_high: assert property (@(posedge clk_i) disable iff (!arst_i)
      (state == S_IDLE) |-> txd_o);

endmodule

`default_nettype wire

// File: logic/uart_settings.svh
/* sizes and APB register map of the UART
   offsets are byte addresses, TXDATA and RXDATA share one offset */
`ifndef UART_SETTINGS_SVH
`define UART_SETTINGS_SVH

`define UART_DIV_W      16      // bit duration register width
`define UART_FIFO_DEPTH 4       // entries per fifo
`define UART_ADDR_W     4       // apb address width

`define UART_REG_DIV    4'h0    // bit duration in clock cycles
`define UART_REG_CTRL   4'h4    // tx en, rx en, soft reset
`define UART_REG_STATUS 4'h8    // tx full, tx idle, rx not empty, overrun
`define UART_REG_TXDATA 4'hC    // write side
`define UART_REG_RXDATA 4'hC    // read side

`endif

// File: logic/uart_top.sv
/* UART top: APB registers, tx and rx FIFOs and the two serial engines
   soft reset from CTRL clears both engines and both FIFOs */
`timescale 1ns/100ps
`default_nettype none
`include "uart_settings.svh"

module uart_top (
   input  logic                    clk_i,
   input  logic                    arst_i,
   input  logic                    psel_i,
   input  logic                    penable_i,
   input  logic                    pwrite_i,
   input  logic [`UART_ADDR_W-1:0] paddr_i,
   input  logic [31:0]             pwdata_i,
   output logic [31:0]             prdata_o,
   output logic                    pready_o,
   output logic                    pslverr_o,
   input  logic                    rxd_i,
   input  logic                    cts_i,
   output logic                    txd_o,
   output logic                    rts_o
);

   logic [`UART_DIV_W-1:0] bit_duration;
   logic                   tx_en;
   logic                   rx_en;
   logic                   soft_rst;
   logic                   tx_push;
   logic                   tx_pop;
   logic                   tx_full;
   logic                   tx_empty;
   logic                   tx_idle;
   logic                   rx_push;
   logic                   rx_pop;
   logic                   rx_full;
   logic                   rx_empty;
   logic                   overrun;
   uart_pkg::byte_t        tx_data;
   uart_pkg::byte_t        tx_head;
   uart_pkg::rx_entry_t    rx_entry;
   uart_pkg::rx_entry_t    rx_head;

   uart_apb_regs u_regs (
      .clk_i(clk_i), .arst_i(arst_i),
      .psel_i(psel_i), .penable_i(penable_i), .pwrite_i(pwrite_i),
      .paddr_i(paddr_i), .pwdata_i(pwdata_i),
      .prdata_o(prdata_o), .pready_o(pready_o), .pslverr_o(pslverr_o),
      .bit_duration_o(bit_duration), .tx_en_o(tx_en), .rx_en_o(rx_en),
      .soft_rst_o(soft_rst),
      .tx_push_o(tx_push), .tx_data_o(tx_data), .tx_full_i(tx_full),
      .rx_pop_o(rx_pop), .rx_head_i(rx_head), .rx_empty_i(rx_empty),
      .tx_idle_i(tx_idle), .overrun_i(overrun)
   );

   ////////////////////////////////////////////////////////////
   // buffers
   uart_fifo #(
      .payload_t(uart_pkg::byte_t),
      .DEPTH    (`UART_FIFO_DEPTH)
   ) u_tx_fifo (
      .clk_i(clk_i), .arst_i(arst_i), .clear_i(soft_rst),
      .push_i(tx_push), .data_i(tx_data), .pop_i(tx_pop),
      .head_o(tx_head), .full_o(tx_full), .empty_o(tx_empty)
   );

   uart_fifo #(
      .payload_t(uart_pkg::rx_entry_t),
      .DEPTH    (`UART_FIFO_DEPTH)
   ) u_rx_fifo (
      .clk_i(clk_i), .arst_i(arst_i), .clear_i(soft_rst),
      .push_i(rx_push), .data_i(rx_entry), .pop_i(rx_pop),
      .head_o(rx_head), .full_o(rx_full), .empty_o(rx_empty)
   );

   ////////////////////////////////////////////////////////////
   // serial engines
   uart_serial_tx u_tx (
      .clk_i(clk_i), .arst_i(arst_i), .soft_rst_i(soft_rst),
      .tx_en_i(tx_en), .bit_duration_i(bit_duration),
      .data_i(tx_head), .empty_i(tx_empty), .cts_i(cts_i),
      .pop_o(tx_pop), .txd_o(txd_o), .idle_o(tx_idle)
   );

   uart_serial_rx u_rx (
      .clk_i(clk_i), .arst_i(arst_i), .soft_rst_i(soft_rst),
      .rx_en_i(rx_en), .bit_duration_i(bit_duration),
      .rxd_i(rxd_i), .full_i(rx_full),
      .push_o(rx_push), .entry_o(rx_entry), .overrun_o(overrun), .rts_o(rts_o)
   );

endmodule

`default_nettype wire

// File: verif/uart_patterns.txt
# hex fields. N name | W addr data err | R addr data err | P status_mask value | T rts
# S rx_byte stop_bit | E tx_byte | C cts | Q quiet_cycles
N setup
W 0 00000002 0
R 0 00000004 0
W 0 00000010 0
W 4 00000003 0
R 8 00000002 0
T 1
N tx_frame
W C 000000A5 0
E A5
P 2 2
N rx_frame
S 3C 1
P 4 4
R C 0000003C 0
S 5A 0
P 4 4
R C 0000015A 0
N err_resp
R C 00000000 1
R 2 00000000 1
W 1 00000000 1
N cts_hold
C 0
W C 00000011 0
W C 00000022 0
W C 00000033 0
W C 00000044 0
W C 00000055 1
R 8 00000001 0
Q 100
C 1
E 11
E 22
E 33
E 44
P 2 2
N rx_overrun
S 01 1
S 02 1
S 03 1
T 1
S 04 1
T 0
S 05 1
P 8 8
R 8 0000000E 0
R C 00000001 0
R C 00000002 0
R C 00000003 0
R C 00000004 0
R 8 0000000A 0
T 1
W 8 00000008 0
R 8 00000002 0
N soft_reset
C 0
W C 00000066 0
W C 00000077 0
S 81 1
P 4 4
R 8 00000004 0
W 4 00000007 0
R 8 00000002 0
R 0 00000010 0
R 4 00000003 0
C 1
Q 100

// File: verif/uart_tb.sv
/* reads verif/uart_patterns.txt relative to the project root, one operation per line
   rxd frames and txd checks assume DIV is programmed to 16 clock cycles */
`timescale 1ns/100ps
`default_nettype none
`include "uart_settings.svh"

module uart_tb;

   localparam int          BIT_CYC   = 16;      // DIV set by the patterns
   localparam int          WAIT_MAX  = 4000;    // cycles per wait
   localparam int          POLL_MAX  = 500;     // status reads per poll
   localparam logic [31:0] LFSR_TAPS = 32'h8020_0003;

   logic                    clk;
   logic                    arst;
   logic                    psel;
   logic                    penable;
   logic                    pwrite;
   logic [`UART_ADDR_W-1:0] paddr;
   logic [31:0]             pwdata;
   logic [31:0]             prdata;
   logic                    pready;
   logic                    pslverr;
   logic                    rxd;
   logic                    cts;
   logic                    txd;
   logic                    rts;
   logic [31:0]             lfsr;
   int                      checks;
   int                      mismatches;
   int                      failures;      // timeouts and pattern file errors
   string                   test_name;

   uart_tb_clock u_clock (.clk_o(clk));

   uart_top DUT (
      .clk_i(clk), .arst_i(arst),
      .psel_i(psel), .penable_i(penable), .pwrite_i(pwrite),
      .paddr_i(paddr), .pwdata_i(pwdata),
      .prdata_o(prdata), .pready_o(pready), .pslverr_o(pslverr),
      .rxd_i(rxd), .cts_i(cts), .txd_o(txd), .rts_o(rts)
   );

   ////////////////////////////////////////////////////////////
   // checks
   function automatic logic rand_bit();
      logic out;
      out  = lfsr[0];
      lfsr = lfsr >> 1;
      if (out)
         lfsr = lfsr ^ LFSR_TAPS;   // galois feedback
      return out;
   endfunction

   task automatic check_value(input string what, input logic [31:0] exp,
                              input logic [31:0] got);
      checks++;
      assert (got === exp) else begin
         mismatches++;
         $display("mismatch %s %s: expected %h, actual %h", test_name, what, exp, got);
      end
   endtask

   task automatic check_timeout(input string what, input int waited, input int limit);
      assert (waited < limit) else begin
         failures++;
         $display("timeout in %s: %s not seen within %0d tries", test_name, what, limit);
      end
   endtask

   task automatic check_args(input int got, input int want);
      assert (got == want) else begin
         failures++;
         $display("error in %s: pattern line has %0d of %0d fields", test_name, got, want);
      end
   endtask

   ////////////////////////////////////////////////////////////
   // bus and line drivers
   task automatic apb_transfer(input logic write, input logic [`UART_ADDR_W-1:0] addr,
                               input logic [31:0] wdata, output logic [31:0] rdata,
                               output logic err);
      int waited;
      @(posedge clk);
      psel    <= 1'b1;                // setup
      penable <= 1'b0;
      pwrite  <= write;
      paddr   <= addr;
      pwdata  <= wdata;
      @(posedge clk);
      penable <= 1'b1;                // access
      waited = 0;
      @(negedge clk);
      while (pready !== 1'b1 && waited < WAIT_MAX) begin
         @(negedge clk);
         waited++;
      end
      check_timeout("pready", waited, WAIT_MAX);
      rdata = prdata;
      err   = pslverr;
      @(posedge clk);
      psel    <= 1'b0;
      penable <= 1'b0;
      pwrite  <= 1'b0;
   endtask

   task automatic poll_status(input logic [31:0] mask, input logic [31:0] value);
      logic [31:0] rdata;
      logic        err;
      int          reads;
      reads = 0;
      apb_transfer(1'b0, `UART_REG_STATUS, 32'b0, rdata, err);
      while ((rdata & mask) != value && reads < POLL_MAX) begin
         apb_transfer(1'b0, `UART_REG_STATUS, 32'b0, rdata, err);
         reads++;
      end
      check_timeout("status bits", reads, POLL_MAX);
   endtask

   task automatic send_rx_frame(input logic [7:0] data, input logic stop);
      logic [9:0] frame;
      logic [3:0] extra;
      int         gap;
      extra = '0;
      repeat (4)
         extra = {extra[2:0], rand_bit()};
      gap   = 2 * BIT_CYC + int'(extra);   // idle line before the start bit
      frame = {stop, data, 1'b0};
      repeat (gap) @(posedge clk);
      repeat (10) begin
         @(posedge clk);
         rxd <= frame[0];
         frame = frame >> 1;
         repeat (BIT_CYC - 1) @(posedge clk);
      end
      @(posedge clk);
      rxd <= 1'b1;                    // back to mark after a bad stop bit
   endtask

   task automatic expect_tx_frame(input logic [7:0] data);
      logic [9:0] frame;
      logic [9:0] seen;
      logic [3:0] bit_idx;
      int         waited;
      int         glitches;
      frame    = {1'b1, data, 1'b0};
      seen     = '0;
      glitches = 0;
      waited   = 0;
      @(negedge clk);
      while (txd !== 1'b0 && waited < WAIT_MAX) begin
         @(negedge clk);
         waited++;
      end
      check_timeout("txd start bit", waited, WAIT_MAX);
      if (waited < WAIT_MAX) begin
         for (int c = 0; c < 10 * BIT_CYC; c++) begin
            if (c > 0)
               @(negedge clk);
            bit_idx = 4'(c / BIT_CYC);
            if (txd !== frame[bit_idx])
               glitches++;            // every cycle of a bit must match
            if (c % BIT_CYC == BIT_CYC / 2)
               seen[bit_idx] = txd;   // bit center
         end
         check_value("txd frame", {22'b0, frame}, {22'b0, seen});
         check_value("txd bit timing", 32'd0, 32'(glitches));
      end
   endtask

   task automatic check_quiet(input int cycles);
      int lows;
      lows = 0;
      repeat (cycles) begin
         @(negedge clk);
         if (txd !== 1'b1)
            lows++;
      end
      check_value("txd low cycles", 32'd0, 32'(lows));
   endtask

   task automatic wait_rts(input logic value);
      int waited;
      waited = 0;
      @(negedge clk);
      while (rts !== value && waited < WAIT_MAX) begin
         @(negedge clk);
         waited++;
      end
      check_timeout("rts level", waited, WAIT_MAX);
   endtask

   task automatic set_cts(input logic value);
      @(posedge clk);
      cts <= value;
      repeat (2) @(posedge clk);      // two-flop synchronizer in the DUT
   endtask

   ////////////////////////////////////////////////////////////
   // pattern runner
   initial begin
      int          fd;
      int          n;
      int          ops;
      string       op;
      string       rest;
      logic [31:0] a;
      logic [31:0] b;
      logic [31:0] c;
      logic [31:0] rdata;
      logic        err;
      checks     = 0;
      mismatches = 0;
      failures   = 0;
      test_name  = "reset";
      lfsr       = 32'd93896;
      arst    <= 1'b0;
      psel    <= 1'b0;
      penable <= 1'b0;
      pwrite  <= 1'b0;
      paddr   <= '0;
      pwdata  <= '0;
      rxd     <= 1'b1;
      cts     <= 1'b1;
      repeat (10) @(posedge clk);
      arst <= 1'b1;
      @(negedge clk);
      check_value("txd", 32'd1, {31'b0, txd});
      check_value("rts", 32'd0, {31'b0, rts});
      check_value("pslverr", 32'd0, {31'b0, pslverr});

      fd = $fopen("verif/uart_patterns.txt", "r");
      if (fd == 0) begin
         failures++;
         $display("error: cannot open verif/uart_patterns.txt");
      end else begin
         ops = 0;
         while (!$feof(fd) && ops < 1000) begin
            ops++;
            n = $fscanf(fd, "%s", op);
            if (n != 1)
               continue;
            if (op == "#") begin
               n = $fgets(rest, fd);
            end else if (op == "N") begin
               n = $fscanf(fd, "%s", test_name);
            end else if (op == "W") begin
               n = $fscanf(fd, "%h %h %h", a, b, c);
               check_args(n, 3);
               apb_transfer(1'b1, a[`UART_ADDR_W-1:0], b, rdata, err);
               check_value("write pslverr", c, {31'b0, err});
            end else if (op == "R") begin
               n = $fscanf(fd, "%h %h %h", a, b, c);
               check_args(n, 3);
               apb_transfer(1'b0, a[`UART_ADDR_W-1:0], 32'b0, rdata, err);
               check_value("read data", b, rdata);
               check_value("read pslverr", c, {31'b0, err});
            end else if (op == "P") begin
               n = $fscanf(fd, "%h %h", a, b);
               check_args(n, 2);
               poll_status(a, b);
            end else if (op == "S") begin
               n = $fscanf(fd, "%h %h", a, b);
               check_args(n, 2);
               send_rx_frame(a[7:0], b[0]);
            end else if (op == "E") begin
               n = $fscanf(fd, "%h", a);
               check_args(n, 1);
               expect_tx_frame(a[7:0]);
            end else if (op == "C") begin
               n = $fscanf(fd, "%h", a);
               check_args(n, 1);
               set_cts(a[0]);
            end else if (op == "T") begin
               n = $fscanf(fd, "%h", a);
               check_args(n, 1);
               wait_rts(a[0]);
            end else if (op == "Q") begin
               n = $fscanf(fd, "%h", a);
               check_args(n, 1);
               check_quiet(int'(a));
            end else begin
               failures++;
               $display("error in %s: unknown operation %s in pattern file", test_name, op);
            end
         end
         $fclose(fd);
      end
      if (checks == 0) begin
         failures++;
         $display("error: no checks ran");
      end

      $display("checks %0d, mismatches %0d, other errors %0d", checks, mismatches, failures);
      if (mismatches == 0 && failures == 0) begin
         $display("Result: PASSED");
      end else begin
         $display("Result: FAILED");
      end
      $finish;
   end

endmodule

`default_nettype wire

// File: verif/uart_tb_clock.sv
/* free-running testbench clock, 8 ns period, starts low */
`timescale 1ns/100ps
`default_nettype none

module uart_tb_clock (
   output logic clk_o
);

   localparam real HALF_PERIOD = 4.0;   // ns

   initial begin
      clk_o = 1'b0;
      forever begin
         #(HALF_PERIOD);
         clk_o = ~clk_o;
      end
   end

endmodule

`default_nettype wire
